// File: ninjin_pkg.sv
package ninjin_pkg;

  // ==================================================
  // Host bus
  // ==================================================
  localparam int addr_bits = 12;
  localparam int word_bits = 32;

  typedef logic [addr_bits-1:0] addr_t;
  typedef logic [word_bits-1:0] word_t;

  // Register offsets
  localparam addr_t reg_ctrl       = 12'h000;
  localparam addr_t reg_shape      = 12'h004;
  localparam addr_t reg_opt        = 12'h008;
  localparam addr_t reg_in_offset  = 12'h00C;
  localparam addr_t reg_out_offset = 12'h010;

  // Memory windows with one 32-bit word per entry
  localparam addr_t img_win_base  = 12'h400;
  localparam int    img_win_words = 256;
  localparam addr_t net_win_base  = 12'h800;
  localparam int    net_win_words = 512;

  // CTRL fields
  localparam int ctrl_start_bit = 0;
  localparam int ctrl_busy_bit  = 0;
  localparam int ctrl_done_bit  = 1;

  // OPT fields with qbits in the low nibble
  localparam int opt_bias_bit = 4;
  localparam int opt_relu_bit = 5;

endpackage

// File: gobou_pkg.sv
package gobou_pkg;

  // ==================================================
  // Data path widths and memory sizes
  // ==================================================
  localparam int DWIDTH  = 16;
  localparam int IMGSIZE = 8;
  localparam int NETSIZE = 9;
  localparam int LWIDTH  = 16;
  localparam int QWIDTH  = 4;

  // Weight memory capacity in words
  localparam int NETWORDS = 2 ** NETSIZE;

  typedef logic signed [DWIDTH-1:0]   pixel_t;
  typedef logic signed [2*DWIDTH-1:0] acc_t;
  typedef logic [IMGSIZE-1:0]         img_addr_t;
  typedef logic [NETSIZE-1:0]         net_addr_t;

  // Dense layer setup
  // Weights of output o at o*(total_in+1)+i and the bias right after them
  typedef struct packed {
    logic [LWIDTH-1:0] total_out;
    logic [LWIDTH-1:0] total_in;
    img_addr_t         in_offset;
    img_addr_t         out_offset;
    logic [QWIDTH-1:0] qbits;
    logic              bias_en;
    logic              relu_en;
  } layer_cfg_t;

  typedef struct packed {
    logic      we;
    img_addr_t addr;
    pixel_t    wdata;
  } img_port_t;

endpackage

// File: ninjin_regs.sv
`timescale 1ns/1ns

module ninjin_regs (
  input  logic                  clk,
  input  logic                  xrst,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  ninjin_pkg::addr_t     paddr,
  input  ninjin_pkg::word_t     pwdata,
  output ninjin_pkg::word_t     prdata,
  output logic                  pready,
  output logic                  pslverr,
  input  logic                  busy,
  input  logic                  done,
  input  gobou_pkg::pixel_t     img_rdata,
  output gobou_pkg::layer_cfg_t cfg,
  output logic                  start,
  output gobou_pkg::img_port_t  host_img,
  output logic                  host_img_rd,
  output logic                  net_we,
  output gobou_pkg::net_addr_t  net_waddr,
  output gobou_pkg::pixel_t     net_wdata
);
  import ninjin_pkg::*;
  import gobou_pkg::*;

  logic  access;
  logic  reg_hit;
  logic  img_hit;
  logic  net_hit;
  logic  win_err;
  logic  img_rd_ok;
  logic  reg_wr;
  logic  rd_wait;
  logic  done_flag;
  word_t reg_rdata;

  // ==================================================
  // Address decode
  // ==================================================
  assign access    = psel && penable;
  assign img_hit   = paddr >= img_win_base && paddr < img_win_base + 4 * img_win_words;
  assign net_hit   = paddr >= net_win_base && paddr < net_win_base + 4 * net_win_words;
  // Net window is write-only and both windows belong to the core while busy
  assign win_err   = (img_hit && busy) || (net_hit && (busy || !pwrite));
  assign img_rd_ok = img_hit && !pwrite && !busy;
  assign reg_wr    = access && pwrite && reg_hit;

  always_comb begin
    reg_hit   = 1'b1;
    reg_rdata = '0;
    case (paddr)
      reg_ctrl: begin
        reg_rdata[ctrl_busy_bit] = busy;
        reg_rdata[ctrl_done_bit] = done_flag;
      end
      reg_shape: reg_rdata = {cfg.total_out, cfg.total_in};
      reg_opt: begin
        reg_rdata[QWIDTH-1:0]   = cfg.qbits;
        reg_rdata[opt_bias_bit] = cfg.bias_en;
        reg_rdata[opt_relu_bit] = cfg.relu_en;
      end
      reg_in_offset:  reg_rdata[IMGSIZE-1:0] = cfg.in_offset;
      reg_out_offset: reg_rdata[IMGSIZE-1:0] = cfg.out_offset;
      default: reg_hit = 1'b0;
    endcase
  end

  // Image reads take one wait cycle for the synchronous buffer
  assign pready  = access && (!img_rd_ok || rd_wait);
  assign pslverr = access && (win_err || !(reg_hit || img_hit || net_hit));
  assign prdata  = rd_wait ? word_t'(img_rdata) : reg_rdata;

  // ==================================================
  // Memory windows
  // ==================================================
  always_comb begin
    host_img.we    = access && pwrite && img_hit && !busy;
    host_img.addr  = paddr[IMGSIZE+1:2];
    host_img.wdata = pwdata[DWIDTH-1:0];
  end

  assign host_img_rd = access && img_rd_ok && !rd_wait;
  assign net_we      = access && pwrite && net_hit && !busy;
  assign net_waddr   = paddr[NETSIZE+1:2];
  assign net_wdata   = pwdata[DWIDTH-1:0];

  // ==================================================
  // Registers and run control
  // ==================================================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      cfg       <= '0;
      start     <= 1'b0;
      done_flag <= 1'b0;
      rd_wait   <= 1'b0;
    end else begin
      rd_wait <= host_img_rd;
      // Second start before busy shows up is dropped as well
      start   <= reg_wr && paddr == reg_ctrl && pwdata[ctrl_start_bit] && !busy && !start;
      if (start)
        done_flag <= 1'b0;
      else if (done)
        done_flag <= 1'b1;
      if (reg_wr) begin
        case (paddr)
          reg_shape: begin
            cfg.total_out <= pwdata[2*LWIDTH-1:LWIDTH];
            cfg.total_in  <= pwdata[LWIDTH-1:0];
          end
          reg_opt: begin
            cfg.qbits   <= pwdata[QWIDTH-1:0];
            cfg.bias_en <= pwdata[opt_bias_bit];
            cfg.relu_en <= pwdata[opt_relu_bit];
          end
          reg_in_offset:  cfg.in_offset  <= pwdata[IMGSIZE-1:0];
          reg_out_offset: cfg.out_offset <= pwdata[IMGSIZE-1:0];
          default: ;
        endcase
      end
    end
  end

  a_no_start_busy: assert property (
    @(posedge clk) disable iff (!xrst) start |-> !busy
  );

endmodule

// File: ninjin_img_buf.sv
`timescale 1ns/1ns

module ninjin_img_buf (
  input  logic                 clk,
  input  logic                 busy,
  input  gobou_pkg::img_port_t host_img,
  input  logic                 host_img_rd,
  input  gobou_pkg::img_port_t core_img,
  output gobou_pkg::pixel_t    rdata
);
  import gobou_pkg::*;

  pixel_t    mem [2**IMGSIZE];
  img_port_t port;
  logic      re;

  // Core owns the port for the whole run
  assign port = busy ? core_img : host_img;
  assign re   = busy || host_img_rd;

  always_ff @(posedge clk) begin
    if (port.we)
      mem[port.addr] <= port.wdata;
    if (re)
      rdata <= mem[port.addr];
  end

  a_no_host_write_busy: assert property (
    @(posedge clk) busy |-> !host_img.we
  );

endmodule

// File: gobou_net_mem.sv
`timescale 1ns/1ns

module gobou_net_mem (
  input  logic                 clk,
  input  logic                 we,
  input  gobou_pkg::net_addr_t waddr,
  input  gobou_pkg::net_addr_t raddr,
  input  gobou_pkg::pixel_t    wdata,
  output gobou_pkg::pixel_t    rdata
);
  import gobou_pkg::*;

  pixel_t mem [NETWORDS];

  // Read during write to the same word returns the old contents
  always_ff @(posedge clk) begin
    if (we)
      mem[waddr] <= wdata;
    rdata <= mem[raddr];
  end

endmodule

// File: gobou_core.sv
`timescale 1ns/1ns

module gobou_core (
  input  logic                  clk,
  input  logic                  xrst,
  input  logic                  start,
  input  gobou_pkg::layer_cfg_t cfg,
  output gobou_pkg::net_addr_t  net_raddr,
  input  gobou_pkg::pixel_t     net_rdata,
  output gobou_pkg::img_port_t  img,
  input  gobou_pkg::pixel_t     img_rdata,
  output logic                  busy,
  output logic                  done
);
  import gobou_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_read,
    st_wait
  } state_t;

  state_t            state;
  layer_cfg_t        cfg_q;
  logic [LWIDTH-1:0] i_cnt;
  logic [LWIDTH-1:0] o_cnt;
  net_addr_t         net_ptr;
  img_addr_t         rd_addr;
  img_addr_t         wr_addr;
  logic              rd_v;
  logic              rd_last;
  logic              m_v;
  logic              m_last;
  logic              wr_v;
  acc_t              prod;
  acc_t              acc;
  acc_t              sum;
  acc_t              shifted;
  pixel_t            trunc;
  pixel_t            res;

  // ==================================================
  // Sequencer
  // ==================================================
  always_ff @(posedge clk) begin
    if (state == st_idle && start)
      cfg_q <= cfg;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state   <= st_idle;
      i_cnt   <= '0;
      o_cnt   <= '0;
      net_ptr <= '0;
      done    <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            state   <= st_read;
            i_cnt   <= '0;
            o_cnt   <= '0;
            net_ptr <= '0;
          end
        end
        st_read: begin
          // Weights are packed, so the pointer simply runs on
          net_ptr <= net_ptr + 1'b1;
          if (i_cnt == cfg_q.total_in) begin
            i_cnt <= '0;
            state <= st_wait;
          end else begin
            i_cnt <= i_cnt + 1'b1;
          end
        end
        st_wait: begin
          // Hold off reads while the result owns the image port
          if (wr_v) begin
            if (o_cnt + 1'b1 >= cfg_q.total_out) begin
              state <= st_idle;
              done  <= 1'b1;
            end else begin
              o_cnt <= o_cnt + 1'b1;
              state <= st_read;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  assign busy      = state != st_idle;
  assign net_raddr = net_ptr;
  assign rd_addr   = cfg_q.in_offset + i_cnt[IMGSIZE-1:0];

  // ==================================================
  // Multiply-accumulate pipeline
  // ==================================================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      rd_v    <= 1'b0;
      rd_last <= 1'b0;
      m_v     <= 1'b0;
      m_last  <= 1'b0;
      wr_v    <= 1'b0;
      acc     <= '0;
    end else begin
      rd_v    <= state == st_read;
      rd_last <= state == st_read && i_cnt == cfg_q.total_in;
      m_v     <= rd_v;
      m_last  <= rd_last;
      wr_v    <= m_v && m_last;
      if (m_v)
        acc <= m_last ? '0 : sum;
    end
  end

  always_ff @(posedge clk) begin
    // Last word of each output is its bias
    if (rd_last)
      prod <= cfg_q.bias_en ? acc_t'(net_rdata) : '0;
    else
      prod <= img_rdata * net_rdata;
    if (m_v && m_last) begin
      res     <= (cfg_q.relu_en && trunc[DWIDTH-1]) ? '0 : trunc;
      wr_addr <= cfg_q.out_offset + o_cnt[IMGSIZE-1:0];
    end
  end

  // ==================================================
  // Output stage
  // ==================================================
  assign sum     = acc + prod;
  assign shifted = sum >>> cfg_q.qbits;
  assign trunc   = shifted[DWIDTH-1:0];

  always_comb begin
    img.we    = wr_v;
    img.addr  = wr_v ? wr_addr : rd_addr;
    img.wdata = res;
  end

  a_net_fits: assert property (
    @(posedge clk) disable iff (!xrst)
    start |-> 32'(cfg.total_out) * (32'(cfg.total_in) + 32'd1) <= NETWORDS
  );

endmodule

// File: kinpira_top.sv
`timescale 1ns/1ns

module kinpira_top (
  input  logic              clk,
  input  logic              xrst,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  ninjin_pkg::addr_t paddr,
  input  ninjin_pkg::word_t pwdata,
  output ninjin_pkg::word_t prdata,
  output logic              pready,
  output logic              pslverr
);
  import gobou_pkg::*;

  layer_cfg_t cfg;
  logic       start;
  logic       busy;
  logic       done;
  img_port_t  host_img;
  logic       host_img_rd;
  img_port_t  core_img;
  pixel_t     img_rdata;
  logic       net_we;
  net_addr_t  net_waddr;
  pixel_t     net_wdata;
  net_addr_t  net_raddr;
  pixel_t     net_rdata;

  ninjin_regs u_regs (
    .clk         (clk),
    .xrst        (xrst),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .busy        (busy),
    .done        (done),
    .img_rdata   (img_rdata),
    .cfg         (cfg),
    .start       (start),
    .host_img    (host_img),
    .host_img_rd (host_img_rd),
    .net_we      (net_we),
    .net_waddr   (net_waddr),
    .net_wdata   (net_wdata)
  );

  ninjin_img_buf u_img_buf (
    .clk         (clk),
    .busy        (busy),
    .host_img    (host_img),
    .host_img_rd (host_img_rd),
    .core_img    (core_img),
    .rdata       (img_rdata)
  );

  gobou_net_mem u_net_mem (
    .clk   (clk),
    .we    (net_we),
    .waddr (net_waddr),
    .raddr (net_raddr),
    .wdata (net_wdata),
    .rdata (net_rdata)
  );

  gobou_core u_core (
    .clk       (clk),
    .xrst      (xrst),
    .start     (start),
    .cfg       (cfg),
    .net_raddr (net_raddr),
    .net_rdata (net_rdata),
    .img       (core_img),
    .img_rdata (img_rdata),
    .busy      (busy),
    .done      (done)
  );

endmodule

// File: tb_clk.sv
`timescale 1ns/1ns

module tb_clk #(
  parameter int period     = 20,
  parameter int rst_cycles = 16
) (
  output logic clk,
  output logic xrst
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // Release reset off the edge like the rest of the stimulus
  initial begin
    xrst = 1'b0;
    repeat (rst_cycles) @(posedge clk);
    #2 xrst = 1'b1;
  end

endmodule

// File: kinpira_tb.sv
`timescale 1ns/1ns

module kinpira_tb;
  import ninjin_pkg::*;
  import gobou_pkg::*;

  localparam int drive_delay = 2;
  localparam int apb_timeout = 20;
  localparam int rst_timeout = 100;
  localparam int done_polls  = 2000;

  logic  clk;
  logic  xrst;
  logic  psel;
  logic  penable;
  logic  pwrite;
  addr_t paddr;
  word_t pwdata;
  word_t prdata;
  logic  pready;
  logic  pslverr;

  // Host side copies of the buffer, the weights and the layer setup
  pixel_t     img_model [img_win_words];
  pixel_t     net_model [net_win_words];
  layer_cfg_t cfg_model;

  // What the compare process expects of the current transfer
  logic   exp_on;
  logic   exp_is_pixel;
  logic   exp_err;
  word_t  exp_word;
  pixel_t exp_pixel;
  string  exp_name;
  int     checks;

  tb_clk u_clk (
    .clk  (clk),
    .xrst (xrst)
  );

  kinpira_top u_dut (
    .clk     (clk),
    .xrst    (xrst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  // ==================================================
  // Reporting and compare
  // ==================================================
  task automatic abort_run();
    $display("** FAIL **");
    $fatal(1, "run stopped at %0t ns", $time);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s is 0x%08h, expected 0x%08h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      abort_run();
    end
  endtask

  // Sampled mid-cycle in the last access cycle of each transfer
  always @(negedge clk) begin
    if (exp_on && psel && penable && pready) begin
      check_word("pslverr", word_t'(pslverr), word_t'(exp_err));
      if (!pwrite && !exp_err) begin
        if (exp_is_pixel)
          check_pixel(exp_name, pixel_t'(prdata[DWIDTH-1:0]), exp_pixel);
        else
          check_word(exp_name, prdata, exp_word);
      end
      checks++;
    end
  end

  // ==================================================
  // Reference model
  // ==================================================
  function automatic pixel_t ref_dense(input int o);
    acc_t   acc;
    acc_t   shifted;
    pixel_t res;
    int     base;
    int     n_in;
    int     i;
    n_in = int'(cfg_model.total_in);
    base = o * (n_in + 1);
    acc  = '0;
    for (i = 0; i < n_in; i++)
      acc += acc_t'(img_model[int'(cfg_model.in_offset) + i]) * acc_t'(net_model[base + i]);
    if (cfg_model.bias_en)
      acc += acc_t'(net_model[base + n_in]);
    shifted = acc >>> cfg_model.qbits;
    res     = shifted[DWIDTH-1:0];
    if (cfg_model.relu_en && res < 0)
      res = '0;
    return res;
  endfunction

  function automatic word_t field_mask(input addr_t addr);
    case (addr)
      reg_shape:      return 32'hFFFF_FFFF;
      reg_opt:        return word_t'((1 << opt_relu_bit) | (1 << opt_bias_bit) | 15);
      reg_in_offset:  return word_t'(2 ** IMGSIZE - 1);
      reg_out_offset: return word_t'(2 ** IMGSIZE - 1);
      default:        return '0;
    endcase
  endfunction

  function automatic pixel_t small_val();
    int v;
    v = int'($urandom_range(1023)) - 512;
    return pixel_t'(v);
  endfunction

  function automatic addr_t img_addr(input int idx);
    return img_win_base + addr_t'(4 * idx);
  endfunction

  function automatic addr_t net_addr(input int idx);
    return net_win_base + addr_t'(4 * idx);
  endfunction

  // ==================================================
  // APB host
  // ==================================================
  task automatic apb_xfer(input logic wr, input addr_t addr, input word_t wdata,
                          output word_t rdata, output logic err);
    int waited;
    @(posedge clk);
    #drive_delay;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #drive_delay;
    penable = 1'b1;
    waited  = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > apb_timeout) begin
        $display("APB transfer to 0x%03h got no pready in %0d cycles", addr, apb_timeout);
        abort_run();
      end
    end while (!pready);
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #drive_delay;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_expect(input addr_t addr, input word_t data, input logic err);
    word_t rd;
    logic  got_err;
    exp_err = err;
    exp_on  = 1'b1;
    apb_xfer(1'b1, addr, data, rd, got_err);
    exp_on  = 1'b0;
  endtask

  task automatic read_word(input addr_t addr, input word_t exp, input string name);
    word_t rd;
    logic  got_err;
    exp_word     = exp;
    exp_is_pixel = 1'b0;
    exp_err      = 1'b0;
    exp_name     = name;
    exp_on       = 1'b1;
    apb_xfer(1'b0, addr, '0, rd, got_err);
    exp_on       = 1'b0;
  endtask

  task automatic read_pixel(input addr_t addr, input pixel_t exp, input string name);
    word_t rd;
    logic  got_err;
    exp_pixel    = exp;
    exp_is_pixel = 1'b1;
    exp_err      = 1'b0;
    exp_name     = name;
    exp_on       = 1'b1;
    apb_xfer(1'b0, addr, '0, rd, got_err);
    exp_on       = 1'b0;
  endtask

  task automatic read_refused(input addr_t addr);
    word_t rd;
    logic  got_err;
    exp_err = 1'b1;
    exp_on  = 1'b1;
    apb_xfer(1'b0, addr, '0, rd, got_err);
    exp_on  = 1'b0;
  endtask

  task automatic wait_done();
    word_t ctrl;
    logic  err;
    int    polls;
    polls = 0;
    do begin
      apb_xfer(1'b0, reg_ctrl, '0, ctrl, err);
      polls++;
      if (polls > done_polls) begin
        $display("Layer run did not set done in CTRL within %0d polls", done_polls);
        abort_run();
      end
    end while (!ctrl[ctrl_done_bit]);
  endtask

  // ==================================================
  // Layer runs
  // ==================================================
  task automatic pick_layer(input int n_in, input int n_out);
    cfg_model.total_in   = 16'(n_in);
    cfg_model.total_out  = 16'(n_out);
    cfg_model.in_offset  = img_addr_t'($urandom_range(63));
    cfg_model.out_offset = img_addr_t'(128 + $urandom_range(63));
    cfg_model.qbits      = 4'($urandom_range(15));
    cfg_model.bias_en    = 1'($urandom_range(1));
    cfg_model.relu_en    = 1'($urandom_range(1));
  endtask

  task automatic run_layer(input logic disturb, input logic restart);
    int     n_in;
    int     n_w;
    int     idx;
    int     k;
    pixel_t expv;
    word_t  opt;
    n_in = int'(cfg_model.total_in);
    n_w  = (n_in + 1) * int'(cfg_model.total_out);
    for (k = 0; k < n_in; k++) begin
      idx            = int'(cfg_model.in_offset) + k;
      img_model[idx] = small_val();
      write_expect(img_addr(idx), word_t'(img_model[idx]), 1'b0);
    end
    for (k = 0; k < n_w; k++) begin
      // Every (total_in+1)th word is a bias
      if (k % (n_in + 1) == n_in)
        net_model[k] = pixel_t'($urandom);
      else
        net_model[k] = small_val();
      write_expect(net_addr(k), word_t'(net_model[k]), 1'b0);
    end
    opt               = '0;
    opt[QWIDTH-1:0]   = cfg_model.qbits;
    opt[opt_bias_bit] = cfg_model.bias_en;
    opt[opt_relu_bit] = cfg_model.relu_en;
    write_expect(reg_shape, {cfg_model.total_out, cfg_model.total_in}, 1'b0);
    write_expect(reg_opt, opt, 1'b0);
    write_expect(reg_in_offset, word_t'(cfg_model.in_offset), 1'b0);
    write_expect(reg_out_offset, word_t'(cfg_model.out_offset), 1'b0);
    write_expect(reg_ctrl, 32'h1, 1'b0);
    if (disturb) begin
      idx = int'(cfg_model.in_offset);
      write_expect(img_addr(idx), ~word_t'(img_model[idx]), 1'b1);
      write_expect(net_addr(0), ~word_t'(net_model[0]), 1'b1);
      read_refused(12'h200);
      // Still running and done cleared by the start
      read_word(reg_ctrl, 32'h1, "prdata");
    end
    if (restart)
      write_expect(reg_ctrl, 32'h1, 1'b0);
    wait_done();
    read_word(reg_ctrl, 32'h2, "prdata");
    for (k = 0; k < int'(cfg_model.total_out); k++) begin
      idx            = int'(cfg_model.out_offset) + k;
      expv           = ref_dense(k);
      img_model[idx] = expv;
      read_pixel(img_addr(idx), expv, "prdata");
    end
    if (disturb)
      read_pixel(img_addr(int'(cfg_model.in_offset)), img_model[cfg_model.in_offset], "prdata");
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    addr_t regs [5];
    word_t v;
    int    k;
    int    cycles;
    int    max_out;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    exp_on       = 1'b0;
    exp_is_pixel = 1'b0;
    exp_err      = 1'b0;
    exp_word     = '0;
    exp_pixel    = '0;
    exp_name     = "";
    checks       = 0;
    cfg_model    = '0;
    regs         = '{reg_ctrl, reg_shape, reg_opt, reg_in_offset, reg_out_offset};
    void'($urandom(32'h4131));

    cycles = 0;
    while (!xrst) begin
      @(posedge clk);
      cycles++;
      if (cycles > rst_timeout) begin
        $display("Reset was never released");
        abort_run();
      end
    end

    for (k = 0; k < 5; k++)
      read_word(regs[k], '0, "prdata");

    // Random register values with the start bit of CTRL kept clear
    repeat (6) begin
      for (k = 0; k < 5; k++) begin
        v = $urandom;
        if (regs[k] == reg_ctrl)
          v[ctrl_start_bit] = 1'b0;
        write_expect(regs[k], v, 1'b0);
        read_word(regs[k], v & field_mask(regs[k]), "prdata");
      end
    end

    for (k = 0; k < img_win_words; k++) begin
      v            = $urandom;
      img_model[k] = pixel_t'(v[DWIDTH-1:0]);
      write_expect(img_addr(k), v, 1'b0);
    end
    for (k = 0; k < img_win_words; k++)
      read_pixel(img_addr(k), img_model[k], "prdata");

    repeat (6) begin
      k       = int'($urandom_range(63, 1));
      max_out = NETWORDS / (k + 1);
      if (max_out > 16)
        max_out = 16;
      pick_layer(k, int'($urandom_range(max_out, 1)));
      run_layer(1'b0, 1'b0);
    end

    // Long run so that the refused accesses land while busy
    pick_layer(63, 8);
    run_layer(1'b1, 1'b0);

    pick_layer(20, 10);
    run_layer(1'b0, 1'b1);

    if (checks > 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("No transfer was compared");
      abort_run();
    end
  end

endmodule

// File: sim.f
ninjin_pkg.sv
gobou_pkg.sv
ninjin_regs.sv
ninjin_img_buf.sv
gobou_net_mem.sv
gobou_core.sv
kinpira_top.sv
tb_clk.sv
kinpira_tb.sv

// File: Makefile
TOP = kinpira_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
